// ==== src/dma_params.svh ====
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Bus data and address width
`define DMA_DATA_W 32

// On-chip SRAM size in 32-bit words
`define DMA_SRAM_WORDS 256

// Word index width, log2 of DMA_SRAM_WORDS
`define DMA_SRAM_AW 8

// HREADY-low cycles the SRAM adds to every data phase
`define DMA_WAIT_STATES 1

`endif

// ==== src/ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'b00,
        TRANS_BUSY   = 2'b01,
        TRANS_NONSEQ = 2'b10,
        TRANS_SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hsize_t;

    typedef enum logic [2:0] {
        BURST_SINGLE = 3'b000,
        BURST_INCR   = 3'b001,
        BURST_WRAP4  = 3'b010,
        BURST_INCR4  = 3'b011
    } hburst_t;

    typedef enum logic {
        RESP_OKAY  = 1'b0,
        RESP_ERROR = 1'b1
    } hresp_t;

    localparam logic [3:0] HPROT_DATA = 4'b0001;  // Data access, user, no buffer/cache

endpackage

`default_nettype wire

// ==== src/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // Copy engine states
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_RD_ADDR = 3'd1,  // First read address phase, bus otherwise idle
        ST_RD_DATA = 3'd2,  // Read data phase, write address on the bus
        ST_WR_DATA = 3'd3,  // Write data phase, next read address on the bus
        ST_DONE    = 3'd4
    } dma_state_t;

    // Byte count rounded up to words fits in 31 bits
    typedef logic [30:0] word_cnt_t;

endpackage

`default_nettype wire

// ==== src/dma_ahb_master.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_ahb_master
    import ahb_pkg::*;
    import dma_pkg::*;
(
    input  wire                     HCLK,
    input  wire                     HRESETn,
    input  wire                     start,
    input  wire  [`DMA_DATA_W-1:0]  src_addr,
    input  wire  [`DMA_DATA_W-1:0]  dest_addr,
    input  wire  [`DMA_DATA_W-1:0]  size,
    output logic                    busy,
    output logic                    done,
    output logic                    error,
    output logic [`DMA_DATA_W-1:0]  HADDR,
    output htrans_t                 HTRANS,
    output logic                    HWRITE,
    output hsize_t                  HSIZE,
    output hburst_t                 HBURST,
    output logic [3:0]              HPROT,
    output logic                    HMASTLOCK,
    output logic [`DMA_DATA_W-1:0]  HWDATA,
    input  wire  [`DMA_DATA_W-1:0]  HRDATA,
    input  wire                     HREADY,
    input  wire  hresp_t            HRESP
);

    dma_state_t             state;
    dma_state_t             state_nxt;
    word_cnt_t              idx;        // Word being copied
    word_cnt_t              idx_nxt;
    word_cnt_t              idx_inc;
    word_cnt_t              total;
    word_cnt_t              size_words;
    logic [`DMA_DATA_W-1:0] src_q;
    logic [`DMA_DATA_W-1:0] dest_q;
    logic [`DMA_DATA_W-1:0] haddr_nxt;
    htrans_t                htrans_nxt;
    logic                   hwrite_nxt;
    logic                   err_nxt;
    logic                   accept;
    logic                   capture;
    logic                   more_words;

    // Round byte count up to whole words
    assign size_words = {1'b0, size[31:2]} + word_cnt_t'(|size[1:0]);
    assign idx_inc    = idx + word_cnt_t'(1);
    assign more_words = idx_inc < total;
    assign accept     = start && (state == ST_IDLE || state == ST_DONE);

    assign busy  = (state == ST_RD_ADDR) || (state == ST_RD_DATA) || (state == ST_WR_DATA);
    assign done  = (state == ST_DONE);

    // Single word transfers only
    assign HSIZE     = SIZE_WORD;
    assign HBURST    = BURST_SINGLE;
    assign HPROT     = HPROT_DATA;
    assign HMASTLOCK = 1'b0;

    always_comb begin
        state_nxt  = state;
        htrans_nxt = HTRANS;
        hwrite_nxt = HWRITE;
        haddr_nxt  = HADDR;
        idx_nxt    = idx;
        err_nxt    = error;
        capture    = 1'b0;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin
                    err_nxt = 1'b0;
                    idx_nxt = '0;
                    if (size_words == '0) begin
                        state_nxt = ST_DONE;    // Nothing to move
                    end else begin
                        state_nxt  = ST_RD_ADDR;
                        htrans_nxt = TRANS_NONSEQ;
                        hwrite_nxt = 1'b0;
                        haddr_nxt  = src_addr;
                    end
                end
            end
            ST_RD_ADDR: begin
                if (HREADY) begin
                    state_nxt  = ST_RD_DATA;
                    htrans_nxt = TRANS_NONSEQ;
                    hwrite_nxt = 1'b1;
                    haddr_nxt  = dest_q + {idx[29:0], 2'b00};
                end
            end
            ST_RD_DATA: begin
                if (HRESP == RESP_ERROR) begin
                    if (HREADY) begin
                        state_nxt = ST_DONE;
                        err_nxt   = 1'b1;
                    end else begin
                        htrans_nxt = TRANS_IDLE;    // Cancel pending write
                    end
                end else if (HREADY) begin
                    capture   = 1'b1;
                    state_nxt = ST_WR_DATA;
                    if (more_words) begin
                        htrans_nxt = TRANS_NONSEQ;
                        hwrite_nxt = 1'b0;
                        haddr_nxt  = src_q + {idx_inc[29:0], 2'b00};
                    end else begin
                        htrans_nxt = TRANS_IDLE;
                    end
                end
            end
            ST_WR_DATA: begin
                if (HRESP == RESP_ERROR) begin
                    if (HREADY) begin
                        state_nxt = ST_DONE;
                        err_nxt   = 1'b1;
                    end else begin
                        htrans_nxt = TRANS_IDLE;
                    end
                end else if (HREADY) begin
                    idx_nxt = idx_inc;
                    if (more_words) begin
                        // Next read address was just taken
                        state_nxt  = ST_RD_DATA;
                        htrans_nxt = TRANS_NONSEQ;
                        hwrite_nxt = 1'b1;
                        haddr_nxt  = dest_q + {idx_inc[29:0], 2'b00};
                    end else begin
                        state_nxt = ST_DONE;
                    end
                end
            end
            default: begin
                state_nxt  = ST_IDLE;
                htrans_nxt = TRANS_IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state  <= ST_IDLE;
            HTRANS <= TRANS_IDLE;
            HWRITE <= 1'b0;
            idx    <= '0;
            total  <= '0;
            error  <= 1'b0;
        end else begin
            state  <= state_nxt;
            HTRANS <= htrans_nxt;
            HWRITE <= hwrite_nxt;
            idx    <= idx_nxt;
            error  <= err_nxt;
            if (accept) begin
                total <= size_words;
            end
        end
    end

    // Job addresses and the word buffer
    always_ff @(posedge HCLK) begin
        HADDR <= haddr_nxt;
        if (accept) begin
            src_q  <= src_addr;
            dest_q <= dest_addr;
        end
        if (capture) begin
            HWDATA <= HRDATA;
        end
    end

endmodule

`default_nettype wire

// ==== src/ahb_dp_sram.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "dma_params.svh"

module ahb_dp_sram
    import ahb_pkg::*;
(
    input  wire                       HCLK,
    input  wire                       HRESETn,
    input  wire  [`DMA_DATA_W-1:0]    HADDR,
    input  wire  htrans_t             HTRANS,
    input  wire                       HWRITE,
    input  wire  hsize_t              HSIZE,
    input  wire  [`DMA_DATA_W-1:0]    HWDATA,
    output logic [`DMA_DATA_W-1:0]    HRDATA,
    output logic                      HREADY,
    output hresp_t                    HRESP,
    input  wire                       host_en,
    input  wire                       host_we,
    input  wire  [`DMA_SRAM_AW-1:0]   host_addr,
    input  wire  [`DMA_DATA_W-1:0]    host_wdata,
    output logic [`DMA_DATA_W-1:0]    host_rdata
);

    localparam int WAIT = `DMA_WAIT_STATES;
    localparam int WC_W = (WAIT > 1) ? $clog2(WAIT) : 1;

    logic [`DMA_DATA_W-1:0]  mem [`DMA_SRAM_WORDS];
    logic                    ph_valid;  // Data phase in progress
    logic                    ph_write;
    logic                    ph_err;
    logic [`DMA_SRAM_AW-1:0] ph_idx;
    logic [WC_W-1:0]         wait_cnt;
    logic                    addr_phase;
    logic                    bad_xfer;
    logic                    wr_commit;
    logic [`DMA_SRAM_AW-1:0] a_idx;

    assign addr_phase = HREADY && (HTRANS == TRANS_NONSEQ || HTRANS == TRANS_SEQ);
    assign a_idx      = HADDR[`DMA_SRAM_AW+1:2];
    // Out of range or not a word access
    assign bad_xfer   = (HADDR[`DMA_DATA_W-1:`DMA_SRAM_AW+2] != '0) || (HSIZE != SIZE_WORD);
    assign wr_commit  = ph_valid && ph_write && !ph_err && HREADY;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ph_valid <= 1'b0;
            ph_write <= 1'b0;
            ph_err   <= 1'b0;
            wait_cnt <= '0;
            HREADY   <= 1'b1;
            HRESP    <= RESP_OKAY;
        end else if (HREADY) begin
            ph_valid <= addr_phase;
            ph_write <= HWRITE;
            ph_err   <= addr_phase && bad_xfer;
            if (addr_phase && bad_xfer) begin
                HREADY <= 1'b0;     // First ERROR cycle
                HRESP  <= RESP_ERROR;
            end else if (addr_phase && WAIT > 0) begin
                HREADY   <= 1'b0;
                HRESP    <= RESP_OKAY;
                wait_cnt <= WC_W'(WAIT - 1);
            end else begin
                HRESP <= RESP_OKAY;
            end
        end else if (ph_err) begin
            HREADY <= 1'b1;         // Second ERROR cycle
        end else if (wait_cnt == '0) begin
            HREADY <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge HCLK) begin
        if (host_en) begin
            host_rdata <= mem[host_addr];
            if (host_we) begin
                mem[host_addr] <= host_wdata;
            end
        end
        if (wr_commit) begin
            mem[ph_idx] <= HWDATA;  // Comes last so AHB wins a collision
        end
        if (addr_phase) begin
            ph_idx <= a_idx;
        end
        if (addr_phase && !HWRITE && !bad_xfer) begin
            // Forward a write landing on the same word this edge
            HRDATA <= (wr_commit && ph_idx == a_idx) ? HWDATA : mem[a_idx];
        end
    end

endmodule

`default_nettype wire

// ==== src/dma_subsystem_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_subsystem_top
    import ahb_pkg::*;
(
    input  wire                       HCLK,
    input  wire                       HRESETn,
    input  wire                       start,
    input  wire  [`DMA_DATA_W-1:0]    src_addr,
    input  wire  [`DMA_DATA_W-1:0]    dest_addr,
    input  wire  [`DMA_DATA_W-1:0]    size,
    output wire                       busy,
    output wire                       done,
    output wire                       error,
    input  wire                       host_en,
    input  wire                       host_we,
    input  wire  [`DMA_SRAM_AW-1:0]   host_addr,
    input  wire  [`DMA_DATA_W-1:0]    host_wdata,
    output wire  [`DMA_DATA_W-1:0]    host_rdata
);

    // Internal AHB-Lite bus, single slave always selected
    wire [`DMA_DATA_W-1:0] haddr;
    wire [`DMA_DATA_W-1:0] hwdata;
    wire [`DMA_DATA_W-1:0] hrdata;
    wire                   hwrite;
    wire                   hready;
    htrans_t               htrans;
    hsize_t                hsize;
    hresp_t                hresp;

    dma_ahb_master u_dma (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .start     (start),
        .src_addr  (src_addr),
        .dest_addr (dest_addr),
        .size      (size),
        .busy      (busy),
        .done      (done),
        .error     (error),
        .HADDR     (haddr),
        .HTRANS    (htrans),
        .HWRITE    (hwrite),
        .HSIZE     (hsize),
        .HBURST    (),          // SRAM ignores burst, protection and lock
        .HPROT     (),
        .HMASTLOCK (),
        .HWDATA    (hwdata),
        .HRDATA    (hrdata),
        .HREADY    (hready),
        .HRESP     (hresp)
    );

    ahb_dp_sram u_sram (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HADDR      (haddr),
        .HTRANS     (htrans),
        .HWRITE     (hwrite),
        .HSIZE      (hsize),
        .HWDATA     (hwdata),
        .HRDATA     (hrdata),
        .HREADY     (hready),   // HREADYOUT fed back to both sides
        .HRESP      (hresp),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule

`default_nettype wire

// ==== test/tb_dma_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "dma_params.svh"

module tb_dma_subsystem;

    logic                      HCLK;
    logic                      HRESETn;
    logic                      start;
    logic [`DMA_DATA_W-1:0]    src_addr;
    logic [`DMA_DATA_W-1:0]    dest_addr;
    logic [`DMA_DATA_W-1:0]    size;
    logic                      busy;
    logic                      done;
    logic                      error;
    logic                      host_en;
    logic                      host_we;
    logic [`DMA_SRAM_AW-1:0]   host_addr;
    logic [`DMA_DATA_W-1:0]    host_wdata;
    logic [`DMA_DATA_W-1:0]    host_rdata;

    logic [`DMA_DATA_W-1:0]    shadow [`DMA_SRAM_WORDS];  // Expected SRAM contents
    logic [31:0]               lfsr_q;
    int                        checks;
    int                        errors;
    int                        tests_run;
    int                        tests_failed;

    dma_subsystem_top dut_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .start      (start),
        .src_addr   (src_addr),
        .dest_addr  (dest_addr),
        .size       (size),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .host_en    (host_en),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    // Accepted start with a nonzero size clears done and error
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (start && !busy && size != '0) |=> (busy && !done && !error))
    else begin
        $display("FAIL t=%0t busy/done/error exp=100 act=%b%b%b", $time,
                 $sampled(busy), $sampled(done), $sampled(error));
        errors++;
    end

    // Busy only ends with done
    assert property (@(posedge HCLK) disable iff (!HRESETn) busy |=> (busy || done))
    else begin
        $display("FAIL t=%0t busy|done exp=1 act=%b", $time, $sampled(busy || done));
        errors++;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        int b;
        w = '0;
        for (b = 0; b < 32; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    function automatic int word_count(input logic [31:0] sz);
        return int'((64'(sz) + 64'd3) / 64'd4);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp)
        else begin
            $display("FAIL t=%0t %s exp=%b act=%b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic host_write(input logic [`DMA_SRAM_AW-1:0] a, input logic [31:0] d);
        host_en    = 1'b1;
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = d;
        @(negedge HCLK);
        host_en    = 1'b0;
        host_we    = 1'b0;
        shadow[a]  = d;
    endtask

    // One cycle read latency
    task automatic host_read(input logic [`DMA_SRAM_AW-1:0] a, output logic [31:0] d);
        host_en   = 1'b1;
        host_we   = 1'b0;
        host_addr = a;
        @(negedge HCLK);
        host_en   = 1'b0;
        d         = host_rdata;
    endtask

    task automatic compare_mem();
        int i;
        logic [31:0] d;
        for (i = 0; i < `DMA_SRAM_WORDS; i++) begin
            host_read(i[`DMA_SRAM_AW-1:0], d);
            check_eq($sformatf("host_rdata[%0d]", i), shadow[i], d);
        end
    endtask

    // Ascending word copy that stops at an unmapped address
    task automatic copy_model(input logic [31:0] src, input logic [31:0] dest,
                              input logic [31:0] sz, output logic err);
        int i;
        logic [31:0] s;
        logic [31:0] d;
        err = 1'b0;
        for (i = 0; i < word_count(sz) && !err; i++) begin
            s = src + (32'(i) << 2);
            d = dest + (32'(i) << 2);
            if (s >= 32'(`DMA_SRAM_WORDS * 4) || d >= 32'(`DMA_SRAM_WORDS * 4)) begin
                err = 1'b1;
            end else begin
                shadow[d[`DMA_SRAM_AW+1:2]] = shadow[s[`DMA_SRAM_AW+1:2]];
            end
        end
    endtask

    task automatic begin_job(input logic [31:0] src, input logic [31:0] dest,
                             input logic [31:0] sz);
        start     = 1'b1;
        src_addr  = src;
        dest_addr = dest;
        size      = sz;
        @(negedge HCLK);
        start     = 1'b0;
        check_bit("busy", word_count(sz) != 0, busy);
        check_bit("done", word_count(sz) == 0, done);
        check_bit("error", 1'b0, error);
    endtask

    task automatic wait_done(input int words);
        int limit;
        int cnt;
        limit = words * 2 * (2 + `DMA_WAIT_STATES) + 16;
        cnt   = 0;
        while (done !== 1'b1 && cnt < limit) begin
            check_bit("busy", 1'b1, busy);
            @(negedge HCLK);
            cnt++;
        end
        if (done !== 1'b1) begin
            $display("Timeout: done did not rise within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic run_job(input logic [31:0] src, input logic [31:0] dest,
                           input logic [31:0] sz);
        logic exp_err;
        begin_job(src, dest, sz);
        wait_done(word_count(sz));
        copy_model(src, dest, sz, exp_err);
        check_bit("error", exp_err, error);
        check_bit("busy", 1'b0, busy);
        compare_mem();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] d;
        logic        exp_err;
        int          e0;
        int          i;
        HRESETn    = 1'b0;
        start      = 1'b0;
        src_addr   = '0;
        dest_addr  = '0;
        size       = '0;
        host_en    = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        lfsr_q     = 32'h4b6;
        checks     = 0;
        errors     = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(negedge HCLK);
        HRESETn = 1'b1;
        @(negedge HCLK);

        e0 = errors;
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("error", 1'b0, error);
        rand_word(w);
        host_write(8'h55, w);
        host_read(8'h55, d);
        check_eq("host_rdata", w, d);
        for (i = 0; i < `DMA_SRAM_WORDS; i++) begin
            rand_word(w);
            host_write(i[`DMA_SRAM_AW-1:0], w);
        end
        end_test("reset and host port", e0);

        e0 = errors;
        run_job(32'h000, 32'h100, 32'd32);
        end_test("aligned copy", e0);

        e0 = errors;
        run_job(32'h200, 32'h280, 32'd13);  // Rounds up to 4 words
        begin_job(32'h010, 32'h3f0, 32'd0);
        check_bit("busy", 1'b0, busy);
        compare_mem();
        end_test("rounding and size 0", e0);

        e0 = errors;
        begin_job(32'h040, 32'h140, 32'd32);
        repeat (3) @(negedge HCLK);
        check_bit("busy", 1'b1, busy);
        start     = 1'b1;               // Ignored while a job is in flight
        src_addr  = 32'h300;
        dest_addr = 32'h000;
        size      = 32'd64;
        @(negedge HCLK);
        start = 1'b0;
        wait_done(8);
        copy_model(32'h040, 32'h140, 32'd32, exp_err);
        check_bit("error", exp_err, error);
        compare_mem();
        run_job(32'h060, 32'h180, 32'd8);
        end_test("control levels", e0);

        e0 = errors;
        run_job(32'h080, 32'h1000, 32'd8);  // Destination past the SRAM
        check_bit("done", 1'b1, done);
        end_test("error abort", e0);

        e0 = errors;
        run_job(32'h0c0, 32'h0c4, 32'd24);
        end_test("overlapping regions", e0);

        $display("tests %0d failed %0d checks %0d errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/ahb_pkg.sv
src/dma_pkg.sv
src/dma_ahb_master.sv
src/ahb_dp_sram.sv
src/dma_subsystem_top.sv
test/tb_dma_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DMA subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_dma_subsystem \
    -f sources.f \
    -o sim_dma

./obj_dir/sim_dma | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
